//--- hdl/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////
`define PC_WIDTH       16   // Program counter
`define IR_WIDTH       32   // Fetched instruction word
`define REG_WIDTH      16   // Scalar register
`define NUM_RF         16   // Scalar register count
`define REG_IDX_WIDTH  4    // log2(NUM_RF)
`define OPCODE_WIDTH   8    // Opcode field, ir[31:24]

//////////////////////////////////////////////////
// Opcode encodings
//////////////////////////////////////////////////
// ALU group
`define OP_ADD    8'h00
`define OP_ADDI   8'h01
`define OP_AND    8'h04
`define OP_ANDI   8'h05
`define OP_MOV    8'h09
`define OP_MOVI   8'h0A
// Memory group
`define OP_LDW    8'h40
`define OP_STW    8'h41
// Conditional branches, low bits follow the n/z/p mask loosely
`define OP_BRN    8'h27
`define OP_BRZ    8'h28
`define OP_BRP    8'h29
`define OP_BRNZ   8'h2A
`define OP_BRNP   8'h2B
`define OP_BRZP   8'h2C
`define OP_BRNZP  8'h2D
`define OP_NOP    8'hF0

`endif

//--- hdl/decode_pkg.sv
package decode_pkg;

  `include "decode_defines.svh"

  //////////////////////////////////////////////////
  // Enumerations
  //////////////////////////////////////////////////
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    OP_ADD   = `OP_ADD,
    OP_ADDI  = `OP_ADDI,
    OP_AND   = `OP_AND,
    OP_ANDI  = `OP_ANDI,
    OP_MOV   = `OP_MOV,
    OP_MOVI  = `OP_MOVI,
    OP_LDW   = `OP_LDW,
    OP_STW   = `OP_STW,
    OP_BRN   = `OP_BRN,
    OP_BRZ   = `OP_BRZ,
    OP_BRP   = `OP_BRP,
    OP_BRNZ  = `OP_BRNZ,
    OP_BRNP  = `OP_BRNP,
    OP_BRZP  = `OP_BRZP,
    OP_BRNZP = `OP_BRNZP,
    OP_NOP   = `OP_NOP
  } opcodeT;

  // One-hot n/z/p, lines up with the branch mask bits
  typedef enum logic [2:0] {
    CC_NONE = 3'b000,  // Nothing written back since reset
    CC_POS  = 3'b001,
    CC_ZERO = 3'b010,
    CC_NEG  = 3'b100
  } condCodeT;

  //////////////////////////////////////////////////
  // Port groups
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                     valid;
    logic [`PC_WIDTH-1:0]     pc;
    logic [`IR_WIDTH-1:0]     ir;
  } fetchPacketT;

  typedef struct packed {
    logic                      valid;
    logic [`REG_IDX_WIDTH-1:0] regIdx;
    logic [`REG_WIDTH-1:0]     data;
  } writebackT;

  typedef struct packed {
    logic                      valid;
    logic [`PC_WIDTH-1:0]      pc;
    opcodeT                    opcode;
    logic [`REG_IDX_WIDTH-1:0] srcAIdx;
    logic                      srcAUsed;
    logic [`REG_IDX_WIDTH-1:0] srcBIdx;
    logic                      srcBUsed;
    logic [`REG_IDX_WIDTH-1:0] destIdx;
    logic                      writesDest;
    logic                      isBranch;
    logic [2:0]                branchMask;  // {n, z, p}
    logic [`REG_WIDTH-1:0]     imm;
  } decodedInstrT;

  typedef struct packed {
    logic                      valid;
    logic [`REG_IDX_WIDTH-1:0] regIdx;
  } reserveT;

  typedef struct packed {
    logic                 valid;
    logic [`PC_WIDTH-1:0] target;
  } redirectT;

  typedef struct packed {
    logic                      valid;
    logic [`PC_WIDTH-1:0]      pc;
    opcodeT                    opcode;
    logic [`REG_WIDTH-1:0]     src1Value;
    logic [`REG_WIDTH-1:0]     src2Value;
    logic [`REG_IDX_WIDTH-1:0] destIdx;
    logic [`REG_WIDTH-1:0]     imm;
  } issuePacketT;

endpackage

//--- hdl/instr_field_decoder.sv
`timescale 1ns/1ps

module instr_field_decoder
  import decode_pkg::*;
(
  input  fetchPacketT  fetch,
  output decodedInstrT dec
);

  opcodeT rawOp;

  assign rawOp = opcodeT'(fetch.ir[31:24]);  // Opcode field

  //////////////////////////////////////////////////
  // Field split per opcode
  //////////////////////////////////////////////////
  always_comb begin
    dec            = '0;
    dec.valid      = fetch.valid;  // Bubble travels as valid low
    dec.pc         = fetch.pc;
    dec.opcode     = OP_NOP;       // Overwritten for every known opcode
    dec.imm        = fetch.ir[15:0];

    case (rawOp)
      // Two-register ALU ops
      OP_ADD, OP_AND: begin
        dec.opcode     = rawOp;
        dec.srcAIdx    = fetch.ir[19:16];
        dec.srcAUsed   = 1'b1;
        dec.srcBIdx    = fetch.ir[11:8];
        dec.srcBUsed   = 1'b1;
        dec.destIdx    = fetch.ir[23:20];
        dec.writesDest = 1'b1;
      end
      // Register plus immediate, also covers the load base
      OP_ADDI, OP_ANDI, OP_LDW: begin
        dec.opcode     = rawOp;
        dec.srcAIdx    = fetch.ir[19:16];
        dec.srcAUsed   = 1'b1;
        dec.destIdx    = fetch.ir[23:20];
        dec.writesDest = 1'b1;
      end
      OP_MOV: begin
        dec.opcode     = rawOp;
        dec.srcBIdx    = fetch.ir[11:8];   // Copy source rides in slot B
        dec.srcBUsed   = 1'b1;
        dec.destIdx    = fetch.ir[19:16];  // MOV family uses the A field as dest
        dec.writesDest = 1'b1;
      end
      OP_MOVI: begin
        dec.opcode     = rawOp;
        dec.destIdx    = fetch.ir[19:16];
        dec.writesDest = 1'b1;
      end
      OP_STW: begin
        dec.opcode     = rawOp;
        dec.srcAIdx    = fetch.ir[19:16];  // Address base
        dec.srcAUsed   = 1'b1;
        dec.srcBIdx    = fetch.ir[23:20];  // Store data
        dec.srcBUsed   = 1'b1;
      end
      OP_BRN, OP_BRZ, OP_BRP, OP_BRNZ, OP_BRNP, OP_BRZP, OP_BRNZP: begin
        dec.opcode     = rawOp;
        dec.isBranch   = 1'b1;
        case (rawOp)
          OP_BRN:  dec.branchMask = 3'b100;
          OP_BRZ:  dec.branchMask = 3'b010;
          OP_BRP:  dec.branchMask = 3'b001;
          OP_BRNZ: dec.branchMask = 3'b110;
          OP_BRNP: dec.branchMask = 3'b101;
          OP_BRZP: dec.branchMask = 3'b011;
          default: dec.branchMask = 3'b111;  // BRNZP
        endcase
      end
      OP_NOP: ;  // Nothing read, nothing written
      default: begin
        dec.imm = '0;  // Unknown opcode degrades to a clean NOP
      end
    endcase
  end

endmodule

//--- hdl/scoreboard_regfile.sv
`timescale 1ns/1ps

`include "decode_defines.svh"

module scoreboard_regfile
  import decode_pkg::*;
(
  input  logic                      I_CLOCK,
  input  logic                      rst,
  input  writebackT                 wb,
  input  reserveT                   reserve,
  input  logic [`REG_IDX_WIDTH-1:0] srcAIdx,
  input  logic [`REG_IDX_WIDTH-1:0] srcBIdx,
  output logic [`REG_WIDTH-1:0]     srcAValue,
  output logic [`REG_WIDTH-1:0]     srcBValue,
  output logic                      srcABusy,
  output logic                      srcBBusy,
  output condCodeT                  condCode,
  output logic                      ccStable
);

  logic [`REG_WIDTH-1:0] regFile [`NUM_RF];  // Scalar architectural registers
  logic [`NUM_RF-1:0]    regValid;           // Clear while a write is in flight
  condCodeT              ccQ;
  condCodeT              ccNext;

  //////////////////////////////////////////////////
  // Read side with writeback bypass
  //////////////////////////////////////////////////
  function automatic logic wbHits(input logic [`REG_IDX_WIDTH-1:0] idx);
    return wb.valid && (wb.regIdx == idx);
  endfunction

  // Current writeback beats the stored copy
  function automatic logic [`REG_WIDTH-1:0] bypassRead(
    input logic [`REG_IDX_WIDTH-1:0] idx
  );
    return wbHits(idx) ? wb.data : regFile[idx];
  endfunction

  // Pending and not being resolved this cycle
  function automatic logic pending(input logic [`REG_IDX_WIDTH-1:0] idx);
    return !regValid[idx] && !wbHits(idx);
  endfunction

  always_comb begin
    srcAValue = bypassRead(srcAIdx);
    srcBValue = bypassRead(srcBIdx);
    srcABusy  = pending(srcAIdx);
    srcBBusy  = pending(srcBIdx);
  end

  // Branch may only trust the cc once nothing is outstanding
  assign ccStable = (&regValid) && !wb.valid;
  assign condCode = ccQ;

  // Sign, then zero, else positive
  always_comb begin
    if (wb.data[`REG_WIDTH-1]) begin
      ccNext = CC_NEG;
    end else if (wb.data == '0) begin
      ccNext = CC_ZERO;
    end else begin
      ccNext = CC_POS;
    end
  end

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (rst) begin
      for (int i = 0; i < `NUM_RF; i++) begin
        regFile[i] <= '0;
      end
      regValid <= '1;      // Nothing pending out of reset
      ccQ      <= CC_NONE;
    end else begin
      if (wb.valid) begin
        regFile[wb.regIdx]  <= wb.data;
        regValid[wb.regIdx] <= 1'b1;
        ccQ                 <= ccNext;  // Last writeback sets the cc
      end
      // Later assignment wins, so a new reservation overrides the writeback
      if (reserve.valid) begin
        regValid[reserve.regIdx] <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/issue_control.sv
`timescale 1ns/1ps

`include "decode_defines.svh"

module issue_control
  import decode_pkg::*;
(
  input  logic                  I_CLOCK,
  input  logic                  rst,
  input  decodedInstrT          dec,
  input  logic [`REG_WIDTH-1:0] srcAValue,
  input  logic [`REG_WIDTH-1:0] srcBValue,
  input  logic                  srcABusy,
  input  logic                  srcBBusy,
  input  condCodeT              condCode,
  input  logic                  ccStable,
  input  logic                  execStall,
  output logic                  depStall,
  output reserveT               reserve,
  output redirectT              redirect,
  output issuePacketT           issue
);

  logic operandWait;  // Some used source still outstanding
  logic branchWait;   // Branch needs a settled cc
  logic accept;
  logic taken;

  //////////////////////////////////////////////////
  // Hazard detection
  //////////////////////////////////////////////////
  assign operandWait = (dec.srcAUsed && srcABusy) || (dec.srcBUsed && srcBBusy);
  assign branchWait  = dec.isBranch && !ccStable;

  // Only meaningful while fetch offers something
  assign depStall = dec.valid && (operandWait || branchWait || execStall);
  assign accept   = dec.valid && !depStall;

  // BRNZP has every mask bit set and goes even before any writeback
  assign taken = dec.isBranch && ((&dec.branchMask) || |(dec.branchMask & condCode));

  // Destination goes pending at the accepting edge
  assign reserve.valid  = accept && dec.writesDest;
  assign reserve.regIdx = dec.destIdx;

  //////////////////////////////////////////////////
  // Issue and redirect registers
  //////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (rst) begin
      issue.valid    <= 1'b0;
      redirect.valid <= 1'b0;
    end else begin
      // Execute back-pressure freezes the whole packet
      if (!execStall) begin
        issue.valid <= accept && !dec.isBranch;  // Branches never reach execute
        if (accept && !dec.isBranch) begin
          issue.pc        <= dec.pc;
          issue.opcode    <= dec.opcode;
          issue.src1Value <= srcAValue;
          issue.src2Value <= srcBValue;
          issue.destIdx   <= dec.destIdx;
          issue.imm       <= dec.imm;
        end
      end

      redirect.valid <= accept && taken;  // One-cycle pulse to fetch
      if (accept && dec.isBranch) begin
        redirect.target <= dec.pc + dec.imm;  // Wraps mod 2^16
      end
    end
  end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

`include "decode_defines.svh"

module decode_stage
  import decode_pkg::*;
(
  input  logic        I_CLOCK,
  input  logic        rst,
  input  fetchPacketT fetch,
  output logic        depStall,
  input  writebackT   wb,
  input  logic        execStall,
  output issuePacketT issue,
  output redirectT    redirect
);

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////
  decodedInstrT          dec;
  reserveT               reserve;     // Issue control back to scoreboard
  logic [`REG_WIDTH-1:0] srcAValue;
  logic [`REG_WIDTH-1:0] srcBValue;
  logic                  srcABusy;
  logic                  srcBBusy;
  condCodeT              condCode;
  logic                  ccStable;

  // Producer, pure field split
  instr_field_decoder uDecoder (
    .fetch (fetch),
    .dec   (dec)
  );

  // Buffer, registers plus pending bits
  scoreboard_regfile uRegfile (
    .I_CLOCK   (I_CLOCK),
    .rst       (rst),
    .wb        (wb),
    .reserve   (reserve),
    .srcAIdx   (dec.srcAIdx),
    .srcBIdx   (dec.srcBIdx),
    .srcAValue (srcAValue),
    .srcBValue (srcBValue),
    .srcABusy  (srcABusy),
    .srcBBusy  (srcBBusy),
    .condCode  (condCode),
    .ccStable  (ccStable)
  );

  // Consumer, stall and issue
  issue_control uIssue (
    .I_CLOCK   (I_CLOCK),
    .rst       (rst),
    .dec       (dec),
    .srcAValue (srcAValue),
    .srcBValue (srcBValue),
    .srcABusy  (srcABusy),
    .srcBBusy  (srcBBusy),
    .condCode  (condCode),
    .ccStable  (ccStable),
    .execStall (execStall),
    .depStall  (depStall),
    .reserve   (reserve),
    .redirect  (redirect),
    .issue     (issue)
  );

endmodule

//--- dv/decode_tests.svh
//////////////////////////////////////////////////
// Directed tests, included into decode_tb
//////////////////////////////////////////////////

// Operand read for every ALU form
task automatic aluOperandTest();
  fetchPacketT pkt;
  int          i;
  testName = "aluOperandTest";
  for (i = 1; i <= 8; i++) begin
    writeReg(4'(i), nextRand());  // R0 stays at its reset value
  end
  pkt = mkFetch(nextRand(), `OP_ADD, 4'd9, 4'd1, {4'h0, 4'd2, 8'h5a});
  issueAndRetire("ADD", pkt, 4'd9);
  pkt = mkFetch(nextRand(), `OP_AND, 4'd10, 4'd3, {4'h0, 4'd4, 8'hc3});
  issueAndRetire("AND", pkt, 4'd10);
  pkt = mkFetch(nextRand(), `OP_ADDI, 4'd11, 4'd5, nextRand());
  issueAndRetire("ADDI", pkt, 4'd11);
  pkt = mkFetch(nextRand(), `OP_ANDI, 4'd12, 4'd6, nextRand());
  issueAndRetire("ANDI", pkt, 4'd12);
  pkt = mkFetch(nextRand(), `OP_MOV, 4'd0, 4'd13, {4'h0, 4'd7, 8'h00});  // R13 <- R7
  issueAndRetire("MOV", pkt, 4'd13);
endtask

// Reader of a pending register stalls, then takes the bypassed data
task automatic rawBypassTest();
  fetchPacketT pkt;
  logic [15:0] data;
  testName = "rawBypassTest";
  pkt = mkFetch(nextRand(), `OP_MOVI, 4'd0, 4'd3, nextRand());
  sendInstr(pkt);  // R3 goes pending
  checkIssue("MOVI R3", expectIssue(pkt), issue);
  data = nextRand();
  pkt  = mkFetch(nextRand(), `OP_ADD, 4'd4, 4'd3, {4'h0, 4'd5, 8'h00});
  holdUntilWriteback(pkt, 4'd3, data, 1'b0);
  checkIssue("ADD reading bypassed R3", expectIssue(pkt), issue);  // src1 is the wb data
  retire(4'd4);
endtask

// Load reserves its destination, store reads base and data
task automatic loadStoreTest();
  fetchPacketT pkt;
  testName = "loadStoreTest";
  pkt = mkFetch(nextRand(), `OP_LDW, 4'd6, 4'd1, nextRand());
  sendInstr(pkt);
  checkIssue("LDW", expectIssue(pkt), issue);
  pkt = mkFetch(nextRand(), `OP_ADDI, 4'd7, 4'd6, nextRand());  // Uses the load result
  holdUntilWriteback(pkt, 4'd6, nextRand(), 1'b0);
  checkIssue("ADDI after load", expectIssue(pkt), issue);
  retire(4'd7);
  pkt = mkFetch(nextRand(), `OP_STW, 4'd2, 4'd1, nextRand());  // Store R2 at R1 + imm
  sendInstr(pkt);
  checkIssue("STW", expectIssue(pkt), issue);
  pkt = mkFetch(nextRand(), `OP_ADD, 4'd5, 4'd2, {4'h0, 4'd0, 8'h00});  // Reads R2 and R0
  issueAndRetire("ADD after STW", pkt, 4'd5);  // Stalls if the store reserved anything
endtask

// Every branch mask against each cc value, then one behind a pending write
task automatic branchTest();
  logic [7:0]  brOps [7];
  logic [15:0] values [3];
  fetchPacketT pkt;
  int          v;
  int          b;
  testName  = "branchTest";
  brOps     = '{`OP_BRN, `OP_BRZ, `OP_BRP, `OP_BRNZ, `OP_BRNP, `OP_BRZP, `OP_BRNZP};
  values[0] = nextRand() | 16'h8000;                // Negative
  values[1] = 16'h0000;                             // Zero
  values[2] = (nextRand() & 16'h7fff) | 16'h0001;   // Positive
  for (v = 0; v < 3; v++) begin
    writeReg(4'd8, values[v]);
    for (b = 0; b < 7; b++) begin
      pkt = mkFetch(nextRand(), brOps[b], 4'd0, 4'd0, nextRand());
      sendInstr(pkt);
      checkRedirect($sformatf("opcode %h on cc %b", brOps[b], ccModel),
                    expectRedirect(pkt), redirect);
    end
  end
  pkt = mkFetch(nextRand(), `OP_MOVI, 4'd0, 4'd9, nextRand());
  sendInstr(pkt);  // Leaves R9 pending, so the cc is not settled
  checkIssue("MOVI before branch", expectIssue(pkt), issue);
  pkt = mkFetch(nextRand(), `OP_BRN, 4'd0, 4'd0, nextRand());
  holdUntilWriteback(pkt, 4'd9, 16'h8123, 1'b1);  // Negative data flips the cc from positive
  checkRedirect("BRN after pending write", expectRedirect(pkt), redirect);
endtask

// Execute back-pressure holds the packet, writeback still lands
task automatic backPressureTest();
  fetchPacketT addPkt;
  fetchPacketT usePkt;
  issuePacketT held;
  logic [15:0] data;
  testName = "backPressureTest";
  addPkt   = mkFetch(nextRand(), `OP_ADD, 4'd11, 4'd1, {4'h0, 4'd2, 8'h00});
  usePkt   = mkFetch(nextRand(), `OP_ADDI, 4'd12, 4'd10, nextRand());
  data     = nextRand();
  held     = expectIssue(addPkt);
  @(posedge I_CLOCK);
  fetch <= addPkt;
  @(negedge I_CLOCK);
  checkStall("ADD offered", 1'b0, depStall);
  @(posedge I_CLOCK);  // ADD accepted here
  fetch     <= usePkt;
  execStall <= 1'b1;
  repeat (3) begin
    @(negedge I_CLOCK);
    checkIssue("held under back-pressure", held, issue);
    checkStall("back-pressure with fetch valid", 1'b1, depStall);
  end
  @(posedge I_CLOCK);
  fetch <= '0;
  wb    <= {1'b1, 4'd10, data};
  @(negedge I_CLOCK);
  checkIssue("held with fetch idle", held, issue);
  checkStall("back-pressure with fetch idle", 1'b0, depStall);
  @(posedge I_CLOCK);  // R10 written under back-pressure
  wb    <= '0;
  fetch <= usePkt;
  modelWrite(4'd10, data);
  @(negedge I_CLOCK);
  checkStall("fetch valid again", 1'b1, depStall);
  checkIssue("still held", held, issue);
  @(posedge I_CLOCK);
  execStall <= 1'b0;
  @(negedge I_CLOCK);
  checkStall("back-pressure released", 1'b0, depStall);
  @(posedge I_CLOCK);  // ADDI accepted here
  fetch <= '0;
  @(negedge I_CLOCK);
  checkIssue("read of R10 after back-pressure", expectIssue(usePkt), issue);
  retire(4'd11);
  retire(4'd12);
endtask

// Unknown opcode goes out as a NOP and reserves nothing
task automatic unknownOpcodeTest();
  fetchPacketT pkt;
  testName = "unknownOpcodeTest";
  pkt = mkFetch(nextRand(), 8'h77, 4'd5, 4'd3, 16'h1234);
  sendInstr(pkt);
  checkIssue("unknown opcode", expectIssue(pkt), issue);
  pkt = mkFetch(nextRand(), `OP_ADD, 4'd13, 4'd5, {4'h0, 4'd3, 8'h00});  // Reads R5 and R3
  issueAndRetire("ADD after unknown", pkt, 4'd13);
  pkt = mkFetch(nextRand(), `OP_BRNZP, 4'd0, 4'd0, nextRand());
  sendInstr(pkt);  // cc must still be settled
  checkRedirect("BRNZP after unknown", expectRedirect(pkt), redirect);
endtask

//--- dv/decode_tb.sv
`timescale 1ns/1ps

`include "decode_defines.svh"

module decode_tb
  import decode_pkg::*;
();

  localparam int TEST_CYCLES  = 200;  // Rough sum of the directed test lengths
  localparam int ACCEPT_LIMIT = 20;   // Longest wait for a packet to leave fetch

  logic        I_CLOCK;
  logic        rst;
  fetchPacketT fetch;
  logic        depStall;
  writebackT   wb;
  logic        execStall;
  issuePacketT issue;
  redirectT    redirect;

  // Reference state kept next to the DUT
  logic [`REG_WIDTH-1:0] regModel [`NUM_RF];
  condCodeT              ccModel;
  logic [31:0]           rngState;
  string                 testName;
  int                    issueErrors;
  int                    redirectErrors;
  int                    stallErrors;
  int                    otherErrors;

  decode_stage UUT (
    .I_CLOCK   (I_CLOCK),
    .rst       (rst),
    .fetch     (fetch),
    .depStall  (depStall),
    .wb        (wb),
    .execStall (execStall),
    .issue     (issue),
    .redirect  (redirect)
  );

  always #10 I_CLOCK = ~I_CLOCK;  // 20 ns period

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////
  function automatic logic [15:0] nextRand();
    rngState = rngState ^ (rngState << 13);  // xorshift32
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState[15:0];
  endfunction

  // Fields laid out as opcode, dest, srcA, then the 16-bit low half
  function automatic fetchPacketT mkFetch(input logic [15:0] pc, input logic [7:0] op,
                                          input logic [3:0] d, input logic [3:0] a,
                                          input logic [15:0] imm);
    return {1'b1, pc, op, d, a, imm};
  endfunction

  function automatic void modelWrite(input logic [3:0] idx, input logic [15:0] data);
    regModel[idx] = data;
    if (data[15]) begin
      ccModel = CC_NEG;
    end else if (data == 16'h0000) begin
      ccModel = CC_ZERO;
    end else begin
      ccModel = CC_POS;
    end
  endfunction

  // Unused source fields come out as index 0, and R0 is never written here
  function automatic issuePacketT expectIssue(input fetchPacketT pkt);
    issuePacketT e;
    logic [3:0]  a;
    logic [3:0]  b;
    logic [3:0]  d;
    logic        known;
    e     = '0;
    a     = '0;
    b     = '0;
    d     = '0;
    known = 1'b1;
    e.imm = pkt.ir[15:0];
    case (pkt.ir[31:24])
      `OP_ADD, `OP_AND: begin
        a = pkt.ir[19:16];
        b = pkt.ir[11:8];
        d = pkt.ir[23:20];
      end
      `OP_ADDI, `OP_ANDI, `OP_LDW: begin
        a = pkt.ir[19:16];
        d = pkt.ir[23:20];
      end
      `OP_MOV: begin
        b = pkt.ir[11:8];
        d = pkt.ir[19:16];  // MOV family writes the A field
      end
      `OP_MOVI: d = pkt.ir[19:16];
      `OP_STW: begin
        a = pkt.ir[19:16];  // Base
        b = pkt.ir[23:20];  // Store data
      end
      `OP_NOP: ;
      default: begin
        known = 1'b0;
        e.imm = '0;
      end
    endcase
    e.valid     = 1'b1;
    e.pc        = pkt.pc;
    e.opcode    = known ? opcodeT'(pkt.ir[31:24]) : OP_NOP;
    e.src1Value = regModel[a];
    e.src2Value = regModel[b];
    e.destIdx   = d;
    return e;
  endfunction

  function automatic redirectT expectRedirect(input fetchPacketT pkt);
    redirectT   e;
    logic [2:0] mask;  // n, z, p
    case (pkt.ir[31:24])
      `OP_BRN:  mask = 3'b100;
      `OP_BRZ:  mask = 3'b010;
      `OP_BRP:  mask = 3'b001;
      `OP_BRNZ: mask = 3'b110;
      `OP_BRNP: mask = 3'b101;
      `OP_BRZP: mask = 3'b011;
      default:  mask = 3'b111;
    endcase
    e.valid  = (mask == 3'b111) || ((mask & ccModel) != 3'b000);
    e.target = pkt.pc + pkt.ir[15:0];  // Wraps at 16 bits
    return e;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic checkIssue(input string what, input issuePacketT exp, input issuePacketT act);
    if (exp !== act) begin
      issueErrors++;
      $display("Mismatch %s %s: expected %h actual %h", testName, what, exp, act);
    end
  endtask

  // Target only matters when the branch goes
  task automatic checkRedirect(input string what, input redirectT exp, input redirectT act);
    if ((exp.valid && exp !== act) || (!exp.valid && act.valid !== 1'b0)) begin
      redirectErrors++;
      $display("Mismatch %s %s: expected %h actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkStall(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      stallErrors++;
      $display("Mismatch %s %s: expected depStall %b actual %b", testName, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Drive tasks
  //////////////////////////////////////////////////
  task automatic writeReg(input logic [3:0] idx, input logic [15:0] data);
    @(posedge I_CLOCK);
    wb <= {1'b1, idx, data};
    @(posedge I_CLOCK);  // Lands at this edge
    wb <= '0;
    modelWrite(idx, data);
  endtask

  task automatic retire(input logic [3:0] idx);
    writeReg(idx, nextRand());  // Clears the pending bit
  endtask

  // Offers a packet with no hazard expected, returns at the negedge after acceptance
  task automatic sendInstr(input fetchPacketT pkt);
    int waited;
    waited = 0;
    @(posedge I_CLOCK);
    fetch <= pkt;
    @(negedge I_CLOCK);
    checkStall("no hazard expected", 1'b0, depStall);
    while (depStall && waited < ACCEPT_LIMIT) begin
      @(negedge I_CLOCK);
      waited++;
    end
    if (depStall) begin
      otherErrors++;
      $display("%s: fetch packet was never accepted", testName);
    end
    @(posedge I_CLOCK);
    fetch <= '0;
    @(negedge I_CLOCK);
  endtask

  // Packet waits on a pending register until a writeback to it arrives
  task automatic holdUntilWriteback(input fetchPacketT pkt, input logic [3:0] idx,
                                    input logic [15:0] data, input logic stallInWb);
    @(posedge I_CLOCK);
    fetch <= pkt;
    repeat (3) begin
      @(negedge I_CLOCK);
      checkStall("waiting on pending register", 1'b1, depStall);
    end
    @(posedge I_CLOCK);
    wb <= {1'b1, idx, data};
    modelWrite(idx, data);
    @(negedge I_CLOCK);
    checkStall("writeback cycle", stallInWb, depStall);
    @(posedge I_CLOCK);
    wb <= '0;
    if (stallInWb) begin  // Branch waits one more cycle for a settled cc
      @(negedge I_CLOCK);
      checkStall("cycle after writeback", 1'b0, depStall);
      @(posedge I_CLOCK);
    end
    fetch <= '0;
    @(negedge I_CLOCK);
  endtask

  task automatic issueAndRetire(input string what, input fetchPacketT pkt,
                                input logic [3:0] dest);
    sendInstr(pkt);
    checkIssue(what, expectIssue(pkt), issue);
    retire(dest);
  endtask

  `include "decode_tests.svh"

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    I_CLOCK        = 1'b0;
    rst            = 1'b1;
    fetch          = '0;
    wb             = '0;
    execStall      = 1'b0;
    ccModel        = CC_NONE;
    rngState       = 32'h308147ce;
    issueErrors    = 0;
    redirectErrors = 0;
    stallErrors    = 0;
    otherErrors    = 0;
    for (int i = 0; i < `NUM_RF; i++) begin
      regModel[i] = '0;  // Reset value
    end
    repeat (8) @(posedge I_CLOCK);
    rst <= 1'b0;
    aluOperandTest();
    rawBypassTest();
    loadStoreTest();
    branchTest();
    backPressureTest();
    unknownOpcodeTest();
    repeat (2) @(posedge I_CLOCK);
    $display("Errors: issue %0d, redirect %0d, stall %0d, other %0d", issueErrors,
             redirectErrors, stallErrors, otherErrors);
    if (issueErrors + redirectErrors + stallErrors + otherErrors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    repeat (TEST_CYCLES * 4) @(posedge I_CLOCK);
    $display("Watchdog expired after %0d cycles, the tests did not finish", TEST_CYCLES * 4);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hdl
+incdir+dv
hdl/decode_pkg.sv
hdl/instr_field_decoder.sv
hdl/scoreboard_regfile.sv
hdl/issue_control.sv
hdl/decode_stage.sv
dv/decode_tb.sv

//--- Makefile
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TEST PASS

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard hdl/*.sv hdl/*.svh dv/*.sv dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
